// File: Bender.yml
package:
  name: magia_monitor

sources:
  # RTL in compile order
  - magia_mon_pkg.sv
  - sentinel_tracker.sv
  - print_assembler.sv
  - report_collector.sv
  - magia_monitor.sv
  # Testbench, includes tb_magia_monitor_tasks.svh
  - target: test
    include_dirs:
      - .
    files:
      - tb_magia_monitor.sv

// File: filelist.f
+incdir+.
magia_mon_pkg.sv
sentinel_tracker.sv
print_assembler.sv
report_collector.sv
magia_monitor.sv
tb_magia_monitor.sv

// File: magia_mon_pkg.sv
package magia_mon_pkg;

  // Tile grid
  localparam int unsigned N_TILES_X = 2;
  localparam int unsigned N_TILES_Y = 2;
  localparam int unsigned N_TILES   = N_TILES_X * N_TILES_Y;
  localparam int unsigned TILE_W    = 2;  // Tile index, row-major

  // Bus and instruction widths
  localparam int unsigned INSTR_W = 32;
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned DATA_W  = 32;
  localparam int unsigned ID_W    = 2;
  localparam int unsigned N_IDS   = 2 ** ID_W;

  // Sentinel instruction words, addi x0 encodings seen in writeback
  localparam logic [INSTR_W-1:0] SENT_START = 32'h5AA0_0013;
  localparam logic [INSTR_W-1:0] SENT_END   = 32'h5FF0_0013;

  // Print peripheral, aliased for every tile
  localparam logic [ADDR_W-1:0] STDERR_ADDR = 32'hFFFF_0000;
  localparam logic [ADDR_W-1:0] STDIO_ADDR  = 32'hFFFF_0004;
  localparam logic [7:0]        ASCII_LF    = 8'h0A;

  // Line buffer and latency counter sizes
  localparam int unsigned LINE_MAX = 16;
  localparam int unsigned LEN_W    = 5;   // Must hold LINE_MAX itself
  localparam int unsigned LAT_W    = 24;

  // One cycle spent by the sentinel pair itself
  localparam logic [LAT_W-1:0] SENT_OVERHEAD = 24'd1;

  typedef struct packed {
    logic               valid;
    logic [INSTR_W-1:0] instr;
  } wb_instr_t;

  // AW and W channels of one tile toward the print peripheral
  typedef struct packed {
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    logic [ID_W-1:0]   aw_id;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
  } print_wr_t;

  typedef struct packed {
    logic             orphan;  // End seen with no open start
    logic [LAT_W-1:0] cycles;
  } lat_report_t;

  typedef struct packed {
    logic [ID_W-1:0]          id;
    logic [LEN_W-1:0]         len;
    logic                     truncated;
    logic [LINE_MAX-1:0][7:0] chars;  // chars[0] is the first character
  } line_report_t;

  typedef struct packed {
    logic [7:0] code;
  } err_report_t;

  // Sticky overflow, one bit per report stream
  typedef struct packed {
    logic lat;
    logic line;
    logic err;
  } drop_t;

endpackage

// File: magia_monitor.sv
`timescale 1ns/10ps

module magia_monitor (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  magia_mon_pkg::wb_instr_t           i_wb [magia_mon_pkg::N_TILES],
  input  magia_mon_pkg::print_wr_t           i_wr [magia_mon_pkg::N_TILES],
  output logic                               o_lat_valid,
  output magia_mon_pkg::lat_report_t         o_lat,
  output logic [magia_mon_pkg::TILE_W-1:0]   o_lat_tile,
  output logic                               o_line_valid,
  output magia_mon_pkg::line_report_t        o_line,
  output logic [magia_mon_pkg::TILE_W-1:0]   o_line_tile,
  output logic                               o_err_valid,
  output magia_mon_pkg::err_report_t         o_err,
  output logic [magia_mon_pkg::TILE_W-1:0]   o_err_tile,
  output magia_mon_pkg::drop_t               o_drop
);

  import magia_mon_pkg::*;

  // Per-tile report pulses and payloads
  logic [N_TILES-1:0] lat_valid;
  lat_report_t        lat_rep  [N_TILES];
  logic [N_TILES-1:0] line_valid;
  line_report_t       line_rep [N_TILES];
  logic [N_TILES-1:0] err_valid;
  err_report_t        err_rep  [N_TILES];

  logic drop_lat;
  logic drop_line;
  logic drop_err;

  for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
    sentinel_tracker i_sentinel_tracker (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_wb        (i_wb[t]),
      .o_lat_valid (lat_valid[t]),
      .o_lat       (lat_rep[t])
    );

    print_assembler i_print_assembler (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_wr         (i_wr[t]),
      .o_line_valid (line_valid[t]),
      .o_line       (line_rep[t]),
      .o_err_valid  (err_valid[t]),
      .o_err        (err_rep[t])
    );
  end

  report_collector #(.payload_t(lat_report_t)) i_lat_collector (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (lat_valid),
    .i_payload (lat_rep),
    .o_valid   (o_lat_valid),
    .o_payload (o_lat),
    .o_tile    (o_lat_tile),
    .o_drop    (drop_lat)
  );

  report_collector #(.payload_t(line_report_t)) i_line_collector (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (line_valid),
    .i_payload (line_rep),
    .o_valid   (o_line_valid),
    .o_payload (o_line),
    .o_tile    (o_line_tile),
    .o_drop    (drop_line)
  );

  report_collector #(.payload_t(err_report_t)) i_err_collector (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (err_valid),
    .i_payload (err_rep),
    .o_valid   (o_err_valid),
    .o_payload (o_err),
    .o_tile    (o_err_tile),
    .o_drop    (drop_err)
  );

  assign o_drop = '{lat: drop_lat, line: drop_line, err: drop_err};

endmodule

// File: print_assembler.sv
`timescale 1ns/10ps

module print_assembler (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  magia_mon_pkg::print_wr_t    i_wr,
  output logic                        o_line_valid,
  output magia_mon_pkg::line_report_t o_line,
  output logic                        o_err_valid,
  output magia_mon_pkg::err_report_t  o_err
);

  import magia_mon_pkg::*;

  logic            stdio_hit;
  logic            err_hit;
  logic            stdio_armed_q;
  logic            err_armed_q;
  logic [ID_W-1:0] stdio_id_q;

  logic            stdio_beat;
  logic            err_beat;
  logic [ID_W-1:0] beat_id;
  logic [7:0]      beat_byte;
  logic            is_lf;

  // One line buffer per write ID
  logic [LINE_MAX-1:0][7:0] buf_chars [N_IDS];
  logic [LEN_W-1:0]         buf_len   [N_IDS];
  logic [N_IDS-1:0]         buf_trunc;
  logic [LINE_MAX-1:0][7:0] line_chars;

  // Address decode on the AW channel
  assign stdio_hit = i_wr.aw_valid && (i_wr.aw_addr == STDIO_ADDR);
  assign err_hit   = i_wr.aw_valid && (i_wr.aw_addr == STDERR_ADDR);

  // A W beat belongs to an armed AW, or to one in the same cycle
  assign stdio_beat = i_wr.w_valid && (stdio_armed_q || stdio_hit);
  assign err_beat   = i_wr.w_valid && (err_armed_q || err_hit);

  assign beat_id   = stdio_armed_q ? stdio_id_q : i_wr.aw_id;
  assign beat_byte = i_wr.w_data[7:0];
  assign is_lf     = (beat_byte == ASCII_LF);

  // Bytes past the current length read as zero
  always_comb begin
    for (int i = 0; i < LINE_MAX; i++) begin
      if (i < int'(buf_len[beat_id])) begin
        line_chars[i] = buf_chars[beat_id][i];
      end else begin
        line_chars[i] = 8'h00;
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stdio_armed_q <= 1'b0;
      err_armed_q   <= 1'b0;
      stdio_id_q    <= '0;
      buf_trunc     <= '0;
      o_line_valid  <= 1'b0;
      o_err_valid   <= 1'b0;
      for (int k = 0; k < N_IDS; k++) begin
        buf_len[k] <= '0;
      end
    end else begin
      // A beat consumes the older AW, a new AW in that cycle stays armed
      if (stdio_beat) begin
        stdio_armed_q <= stdio_hit && stdio_armed_q;
      end else if (stdio_hit) begin
        stdio_armed_q <= 1'b1;
      end
      if (stdio_hit) begin
        stdio_id_q <= i_wr.aw_id;
      end

      if (err_beat) begin
        err_armed_q <= err_hit && err_armed_q;
      end else if (err_hit) begin
        err_armed_q <= 1'b1;
      end

      if (stdio_beat) begin
        if (is_lf) begin
          buf_len[beat_id]   <= '0;  // Line done, buffer free again
          buf_trunc[beat_id] <= 1'b0;
        end else if (buf_len[beat_id] < LEN_W'(LINE_MAX)) begin
          buf_len[beat_id] <= buf_len[beat_id] + 1'b1;
        end else begin
          buf_trunc[beat_id] <= 1'b1;  // Byte lost
        end
      end

      o_line_valid <= stdio_beat && is_lf;
      o_err_valid  <= err_beat;
    end
  end

  // Character storage
  always_ff @(posedge clk) begin
    if (stdio_beat && !is_lf && (buf_len[beat_id] < LEN_W'(LINE_MAX))) begin
      buf_chars[beat_id][buf_len[beat_id]] <= beat_byte;
    end
  end

  // Report payloads
  always_ff @(posedge clk) begin
    if (stdio_beat && is_lf) begin
      o_line.id        <= beat_id;
      o_line.len       <= buf_len[beat_id];  // LF itself not counted
      o_line.truncated <= buf_trunc[beat_id];
      o_line.chars     <= line_chars;
    end
    if (err_beat) begin
      o_err.code <= beat_byte;
    end
  end

endmodule

// File: report_collector.sv
`timescale 1ns/10ps

module report_collector #(
  parameter type payload_t = logic
) (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  logic [magia_mon_pkg::N_TILES-1:0]  i_valid,
  input  payload_t                           i_payload [magia_mon_pkg::N_TILES],
  output logic                               o_valid,
  output payload_t                           o_payload,
  output logic [magia_mon_pkg::TILE_W-1:0]   o_tile,
  output logic                               o_drop
);

  import magia_mon_pkg::*;

  logic [N_TILES-1:0] slot_full;
  payload_t           slot_data [N_TILES];
  logic [TILE_W-1:0]  rr_ptr;  // Last granted tile

  logic               grant_valid;
  logic [TILE_W-1:0]  grant_idx;

  // Round robin, search starts just after the last grant
  always_comb begin
    logic [TILE_W-1:0] cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int i = 0; i < N_TILES; i++) begin
      cand = TILE_W'((int'(rr_ptr) + 1 + i) % N_TILES);
      if (!grant_valid && slot_full[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      slot_full <= '0;
      rr_ptr    <= TILE_W'(N_TILES - 1);  // Tile 0 wins first
      o_valid   <= 1'b0;
      o_drop    <= 1'b0;
    end else begin
      for (int t = 0; t < N_TILES; t++) begin
        if (i_valid[t]) begin
          if (slot_full[t] && !(grant_valid && (grant_idx == TILE_W'(t)))) begin
            o_drop <= 1'b1;  // Slot still busy, new item lost
          end else begin
            slot_full[t] <= 1'b1;
          end
        end else if (grant_valid && (grant_idx == TILE_W'(t))) begin
          slot_full[t] <= 1'b0;
        end
      end

      o_valid <= grant_valid;
      if (grant_valid) begin
        rr_ptr <= grant_idx;
      end
    end
  end

  // Slot contents and output payload
  always_ff @(posedge clk) begin
    for (int t = 0; t < N_TILES; t++) begin
      if (i_valid[t] && (!slot_full[t] || (grant_valid && (grant_idx == TILE_W'(t))))) begin
        slot_data[t] <= i_payload[t];
      end
    end
    if (grant_valid) begin
      o_payload <= slot_data[grant_idx];
      o_tile    <= grant_idx;
    end
  end

endmodule

// File: sentinel_tracker.sv
`timescale 1ns/10ps

module sentinel_tracker (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  magia_mon_pkg::wb_instr_t   i_wb,
  output logic                       o_lat_valid,
  output magia_mon_pkg::lat_report_t o_lat
);

  import magia_mon_pkg::*;

  logic             is_start;
  logic             is_end;
  logic             open_q;  // Region between start and end
  logic [LAT_W-1:0] cnt_q;

  // Sentinels only count when they really retire
  assign is_start = i_wb.valid && (i_wb.instr == SENT_START);
  assign is_end   = i_wb.valid && (i_wb.instr == SENT_END);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      open_q      <= 1'b0;
      cnt_q       <= '0;
      o_lat_valid <= 1'b0;
    end else begin
      o_lat_valid <= is_end;

      if (is_start) begin
        open_q <= 1'b1;
        cnt_q  <= LAT_W'(1);  // The start cycle counts too
      end else if (is_end) begin
        open_q <= 1'b0;
      end else if (open_q && (cnt_q != '1)) begin
        cnt_q <= cnt_q + 1'b1;  // Saturates at all ones
      end
    end
  end

  // Report payload, latched on the end sentinel
  always_ff @(posedge clk) begin
    if (is_end) begin
      o_lat.orphan <= !open_q;
      if (open_q) begin
        o_lat.cycles <= cnt_q - SENT_OVERHEAD;
      end else begin
        o_lat.cycles <= '0;
      end
    end
  end

endmodule

// File: tb_magia_monitor_tasks.svh
`ifndef TB_MAGIA_MONITOR_TASKS_SVH
`define TB_MAGIA_MONITOR_TASKS_SVH

// Xorshift32 on rng_state
function automatic logic [31:0] next_random();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

// Printable and never a newline
function automatic logic [7:0] random_char();
  return 8'h21 + 8'(next_random() % 94);
endfunction

function automatic string random_text(input int n);
  string s;
  s = "";
  for (int i = 0; i < n; i++) begin
    s = $sformatf("%s%c", s, random_char());
  end
  return s;
endfunction

// Drive point just after the rising edge, all inputs released
task automatic next_cycle();
  @(posedge clk);
  #2;
  for (int t = 0; t < N_TILES; t++) begin
    wb[t] = '0;
    wr[t] = '0;
  end
endtask

task automatic idle(input int n);
  repeat (n) next_cycle();
endtask

task automatic retire(input int tile, input logic [INSTR_W-1:0] instr);
  next_cycle();
  wb[tile].valid = 1'b1;
  wb[tile].instr = instr;
endtask

// AW and W in the current cycle, upper data bits are filler
task automatic put_write(input int tile, input logic [ADDR_W-1:0] addr,
                         input logic [ID_W-1:0] id, input logic [7:0] data);
  logic [31:0] fill;
  fill = next_random();
  wr[tile].aw_valid = 1'b1;
  wr[tile].aw_addr  = addr;
  wr[tile].aw_id    = id;
  wr[tile].w_valid  = 1'b1;
  wr[tile].w_data   = {fill[31:8], data};
endtask

// One byte, either as a single beat or as AW then W
task automatic send_byte(input int tile, input logic [ADDR_W-1:0] addr,
                         input logic [ID_W-1:0] id, input logic [7:0] data);
  logic [31:0]       r;
  logic [DATA_W-1:0] w;
  r = next_random();
  next_cycle();
  put_write(tile, addr, id, data);
  if (r[4]) begin
    w = wr[tile].w_data;
    wr[tile].w_valid = 1'b0;
    next_cycle();
    wr[tile].w_valid = 1'b1;  // W beat for the AW of the previous cycle
    wr[tile].w_data  = w;
  end
endtask

`endif

// File: tb_magia_monitor.sv
`timescale 1ns/10ps

module tb_magia_monitor;

  import magia_mon_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 4000;
  localparam int unsigned DRAIN_LIMIT = 40;

  typedef struct packed {
    logic [TILE_W-1:0] tile;
    logic [31:0]       end_cycle;  // Edge that samples the end sentinel
    lat_report_t       rep;
  } lat_exp_t;

  typedef struct packed {
    logic [TILE_W-1:0] tile;
    line_report_t      rep;
  } line_exp_t;

  typedef struct packed {
    logic [TILE_W-1:0] tile;
    err_report_t       rep;
  } err_exp_t;

  logic              clk;
  logic              arst_n;
  wb_instr_t         wb [N_TILES];
  print_wr_t         wr [N_TILES];
  logic              lat_valid;
  lat_report_t       lat;
  logic [TILE_W-1:0] lat_tile;
  logic              line_valid;
  line_report_t      line;
  logic [TILE_W-1:0] line_tile;
  logic              err_valid;
  err_report_t       err;
  logic [TILE_W-1:0] err_tile;
  drop_t             drop;

  logic [31:0] rng_state;
  int unsigned cycle_cnt = 0;
  int unsigned errors = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  lat_exp_t    lat_q [$];
  line_exp_t   line_q [$];
  err_exp_t    err_q [$];

  magia_monitor i_magia_monitor (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_wb         (wb),
    .i_wr         (wr),
    .o_lat_valid  (lat_valid),
    .o_lat        (lat),
    .o_lat_tile   (lat_tile),
    .o_line_valid (line_valid),
    .o_line       (line),
    .o_line_tile  (line_tile),
    .o_err_valid  (err_valid),
    .o_err        (err),
    .o_err_tile   (err_tile),
    .o_drop       (drop)
  );

  `include "tb_magia_monitor_tasks.svh"

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // Only the first len characters carry meaning
  function automatic bit line_matches(input line_report_t got, input line_report_t exp);
    bit ok;
    ok = (got.id == exp.id) && (got.len == exp.len) && (got.truncated == exp.truncated);
    for (int i = 0; i < LINE_MAX; i++) begin
      if (i < int'(exp.len) && got.chars[i] != exp.chars[i]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  function automatic void expect_lat(input int tile, input logic orphan, input int unsigned cyc);
    lat_exp_t e;
    e.tile       = TILE_W'(tile);
    e.end_cycle  = cycle_cnt + 1;
    e.rep.orphan = orphan;
    e.rep.cycles = LAT_W'(cyc);
    lat_q.push_back(e);
  endfunction

  function automatic void expect_line(input int tile, input logic [ID_W-1:0] id, input string s);
    line_exp_t e;
    e               = '0;
    e.tile          = TILE_W'(tile);
    e.rep.id        = id;
    e.rep.truncated = (s.len() > LINE_MAX);
    e.rep.len       = (s.len() > LINE_MAX) ? LEN_W'(LINE_MAX) : LEN_W'(s.len());
    for (int i = 0; i < LINE_MAX && i < s.len(); i++) begin
      e.rep.chars[i] = s[i];
    end
    line_q.push_back(e);
  endfunction

  function automatic void expect_err(input int tile, input logic [7:0] code);
    err_exp_t e;
    e.tile     = TILE_W'(tile);
    e.rep.code = code;
    err_q.push_back(e);
  endfunction

  // Character i of a line, the newline once the text is used up
  task automatic send_text_char(input int tile, input logic [ID_W-1:0] id, input string s,
                                input int i);
    if (i < s.len()) begin
      send_byte(tile, STDIO_ADDR, id, s[i]);
    end else if (i == s.len()) begin
      expect_line(tile, id, s);
      send_byte(tile, STDIO_ADDR, id, ASCII_LF);
    end
  endtask

  task automatic wait_drained();
    int unsigned n;
    n = 0;
    while ((lat_q.size() + line_q.size() + err_q.size()) != 0 && n < DRAIN_LIMIT) begin
      next_cycle();
      n++;
    end
    assert (n < DRAIN_LIMIT) else begin
      $display("Expected reports did not arrive within %0d cycles", DRAIN_LIMIT);
      errors++;
    end
    idle(N_TILES + 2);  // Room for stray pulses
  endtask

  always @(negedge clk) begin
    lat_exp_t    le;
    line_exp_t   ne;
    err_exp_t    ee;
    int unsigned delay;
    if (arst_n && lat_valid) begin
      assert (lat_q.size() > 0) else begin
        $display("Latency report from tile %0d arrived with none expected", lat_tile);
        errors++;
      end
      if (lat_q.size() > 0) begin
        le    = lat_q.pop_front();
        delay = cycle_cnt - le.end_cycle;
        assert (lat_tile == le.tile && lat == le.rep) else begin
          $display("MISMATCH %0t: latency tile %0d orphan %0b cycles %0d, expected %0d %0b %0d",
                   $time, lat_tile, lat.orphan, lat.cycles, le.tile, le.rep.orphan,
                   le.rep.cycles);
          errors++;
        end
        assert (delay >= 2 && delay <= N_TILES + 1) else begin
          $display("MISMATCH %0t: latency report %0d cycles after its end", $time, delay);
          errors++;
        end
      end
    end
    if (arst_n && line_valid) begin
      assert (line_q.size() > 0) else begin
        $display("Line report from tile %0d arrived with none expected", line_tile);
        errors++;
      end
      if (line_q.size() > 0) begin
        ne = line_q.pop_front();
        assert (line_tile == ne.tile && line_matches(line, ne.rep)) else begin
          $display("MISMATCH %0t: line tile %0d id %0d len %0d trunc %0b, expected %0d %0d %0d %0b",
                   $time, line_tile, line.id, line.len, line.truncated, ne.tile, ne.rep.id,
                   ne.rep.len, ne.rep.truncated);
          errors++;
        end
      end
    end
    if (arst_n && err_valid) begin
      assert (err_q.size() > 0) else begin
        $display("Error report from tile %0d arrived with none expected", err_tile);
        errors++;
      end
      if (err_q.size() > 0) begin
        ee = err_q.pop_front();
        assert (err_tile == ee.tile && err == ee.rep) else begin
          $display("MISMATCH %0t: error tile %0d code %h, expected tile %0d code %h",
                   $time, err_tile, err.code, ee.tile, ee.rep.code);
          errors++;
        end
      end
    end
  end

  task automatic latency_per_tile();
    int unsigned g;
    for (int t = 0; t < N_TILES; t++) begin
      g = 1 + next_random() % 40;
      retire(t, SENT_START);
      idle(1 + next_random() % 8);
      retire(t, SENT_START);  // Restart, count from here
      idle(g - 1);
      retire(t, SENT_END);
      expect_lat(t, 1'b0, g - 1);
      wait_drained();
    end
  endtask

  task automatic orphan_end();
    int t;
    t = next_random() % N_TILES;
    retire(t, SENT_END);
    expect_lat(t, 1'b1, 0);
    wait_drained();
  endtask

  // Tile 3 keeps the line round robin pointing at tile 0 next
  task automatic interleaved_lines();
    logic [ID_W-1:0] id_a;
    logic [ID_W-1:0] id_b;
    string           sa;
    string           sb;
    id_a = ID_W'(next_random());
    id_b = id_a ^ ID_W'(1 + next_random() % 3);
    sa   = random_text(3 + next_random() % 8);
    sb   = random_text(3 + next_random() % 8);
    for (int i = 0; i <= LINE_MAX; i++) begin
      send_text_char(3, id_a, sa, i);
      send_text_char(3, id_b, sb, i);
    end
    wait_drained();
  endtask

  task automatic long_line();
    string           s;
    logic [ID_W-1:0] id;
    s  = random_text(LINE_MAX + 1 + next_random() % 8);
    id = ID_W'(next_random());
    for (int i = 0; i <= s.len(); i++) begin
      send_text_char(3, id, s, i);
    end
    wait_drained();
  endtask

  task automatic stderr_codes();
    logic [7:0] code;
    for (int t = 0; t < N_TILES; t++) begin
      code = 8'(next_random());
      send_byte(t, STDERR_ADDR, ID_W'(next_random()), code);
      expect_err(t, code);
      wait_drained();
    end
  endtask

  task automatic simultaneous_lines();
    string s [N_TILES];
    int    n;
    n = 1 + next_random() % 6;
    for (int t = 0; t < N_TILES; t++) begin
      s[t] = random_text(n);
    end
    for (int i = 0; i <= n; i++) begin
      next_cycle();
      for (int t = 0; t < N_TILES; t++) begin
        if (i == n) begin
          expect_line(t, ID_W'(t), s[t]);  // Last grant was tile 3, so 0 to 3
        end
        put_write(t, STDIO_ADDR, ID_W'(t), (i < n) ? s[t][i] : ASCII_LF);
      end
    end
    wait_drained();
    assert (!drop.line) else begin
      $display("Line drop flag set although no slot overflowed");
      errors++;
    end
    // Tile 0 is granted first, so its next line refills the slot and the third is lost
    next_cycle();
    for (int t = 0; t < N_TILES; t++) begin
      expect_line(t, '0, "");
      put_write(t, STDIO_ADDR, '0, ASCII_LF);
    end
    next_cycle();
    expect_line(0, ID_W'(1), "");
    put_write(0, STDIO_ADDR, ID_W'(1), ASCII_LF);
    next_cycle();
    put_write(0, STDIO_ADDR, ID_W'(2), ASCII_LF);
    wait_drained();
    assert (drop.line && !drop.lat && !drop.err) else begin
      $display("Line drop flag did not set on a slot overflow");
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED", tests_run, name);
    end
  endtask

  initial begin
    int unsigned e0;
    rng_state = 32'h49b9_6316;
    arst_n    = 1'b0;
    for (int t = 0; t < N_TILES; t++) begin
      wb[t] = '0;
      wr[t] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    assert (!lat_valid && !line_valid && !err_valid && drop == '0) else begin
      $display("Outputs not idle after reset");
      errors++;
    end

    e0 = errors;
    latency_per_tile();
    report_test("latency per tile", e0);
    e0 = errors;
    orphan_end();
    report_test("orphan end sentinel", e0);
    e0 = errors;
    interleaved_lines();
    report_test("interleaved stdio lines", e0);
    e0 = errors;
    long_line();
    report_test("truncated line", e0);
    e0 = errors;
    stderr_codes();
    report_test("stderr codes", e0);
    e0 = errors;
    simultaneous_lines();
    report_test("simultaneous lines and overflow", e0);

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
